// ==== source/pipe_config.svh ====
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Datapath word shared by registers, ALU and data memory
`define PIPE_DATA_W       16

// Width of a register number (32 architectural registers)
`define PIPE_REG_ADDR_W   5

// Data memory word address taken from the low ALU result bits
`define PIPE_DMEM_ADDR_W  4

`endif

// ==== source/pipe_pkg.sv ====
`include "pipe_config.svh"

package pipe_pkg;

        // ##########################################################################
        // Basic field types
        // ##########################################################################
        typedef logic [`PIPE_DATA_W-1:0]     data_t;      // Register and memory word
        typedef logic [`PIPE_REG_ADDR_W-1:0] reg_addr_t;  // Register number

        // Instruction opcodes as issued by the decoder front end
        typedef enum logic [2:0] {
                NOP  = 3'd0,
                ADD  = 3'd1,
                SUB  = 3'd2,
                AND  = 3'd3,
                OR   = 3'd4,
                ADDI = 3'd5,
                LW   = 3'd6,
                SW   = 3'd7
        } opcode_e;

        typedef enum logic [1:0] {
                ALU_ADD = 2'd0,
                ALU_SUB = 2'd1,
                ALU_AND = 2'd2,
                ALU_OR  = 2'd3
        } alu_op_e;

        // Operand source codes for the forwarding muxes
        typedef enum logic [1:0] {
                FWD_NONE = 2'd0,    // Value read in ID
                FWD_MEM  = 2'd1,    // EX/MEM ALU result
                FWD_WB   = 2'd2     // MEM/WB write-back data
        } fwd_sel_e;

        // ##########################################################################
        // Pipeline payloads
        // ##########################################################################
        typedef struct packed {
                logic      valid;
                opcode_e   opcode;
                reg_addr_t rs;
                reg_addr_t rt;
                reg_addr_t rd;
                data_t     imm;
        } instr_t;

        typedef struct packed {
                alu_op_e alu_op;
                logic    use_imm;     // Operand B is the immediate
                logic    mem_read;    // LW
                logic    mem_write;   // SW
                logic    write_reg;   // Result goes to rd
        } ctrl_t;

        typedef struct packed {
                ctrl_t     ctrl;
                reg_addr_t rs;
                reg_addr_t rt;
                reg_addr_t rd;
                data_t     imm;
                data_t     rs_data;
                data_t     rt_data;
        } id_ex_t;

        typedef struct packed {
                ctrl_t     ctrl;
                reg_addr_t rd;
                data_t     alu_result;  // Also the memory address
                data_t     store_data;
        } ex_mem_t;

        // Write-back bundle and MEM/WB register layout
        typedef struct packed {
                logic      valid;
                reg_addr_t rd;
                data_t     data;
        } wb_t;

endpackage

// ==== source/pipeline_control.sv ====
`timescale 1ns/1ps

module pipeline_control import pipe_pkg::*; (
        input  instr_t    i_instr,            // Instruction waiting in ID
        input  reg_addr_t i_id_ex_rd,         // Destination of the instruction in EX
        input  logic      i_id_ex_mem_read,   // EX instruction is a load
        output ctrl_t     o_ctrl,             // Decoded control for ID/EX
        output logic      o_stall             // Hold the input one cycle
);

        logic writes_rd;    // Opcode produces a register result

        // Opcode to control mapping
        always_comb begin
                o_ctrl    = '0;
                writes_rd = 1'b0;
                case (i_instr.opcode)
                        ADD:  begin o_ctrl.alu_op = ALU_ADD; writes_rd = 1'b1; end
                        SUB:  begin o_ctrl.alu_op = ALU_SUB; writes_rd = 1'b1; end
                        AND:  begin o_ctrl.alu_op = ALU_AND; writes_rd = 1'b1; end
                        OR:   begin o_ctrl.alu_op = ALU_OR;  writes_rd = 1'b1; end
                        ADDI: begin
                                o_ctrl.alu_op  = ALU_ADD;
                                o_ctrl.use_imm = 1'b1;
                                writes_rd      = 1'b1;
                        end
                        LW: begin
                                o_ctrl.alu_op   = ALU_ADD;    // Address is rs + imm
                                o_ctrl.use_imm  = 1'b1;
                                o_ctrl.mem_read = 1'b1;
                                writes_rd       = 1'b1;
                        end
                        SW: begin
                                o_ctrl.alu_op    = ALU_ADD;
                                o_ctrl.use_imm   = 1'b1;
                                o_ctrl.mem_write = 1'b1;
                        end
                        default: ;                            // NOP leaves everything clear
                endcase
                // r0 is never written
                o_ctrl.write_reg = writes_rd && (i_instr.rd != '0);
                if (!i_instr.valid) begin
                        o_ctrl = '0;                          // Empty slot becomes a bubble
                end
        end

        // Load in EX whose rd is a source of the instruction in ID
        assign o_stall = i_instr.valid && i_id_ex_mem_read &&
                         ((i_instr.rs == i_id_ex_rd) || (i_instr.rt == i_id_ex_rd));

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module register_file import pipe_pkg::*; (
        input  logic      i_clk,
        input  logic      i_rst,
        input  reg_addr_t i_rs,          // Read port A
        input  reg_addr_t i_rt,          // Read port B
        input  wb_t       i_wb,          // Write port from MEM/WB
        output data_t     o_rs_data,
        output data_t     o_rt_data
);

        localparam int NUM_REGS = 1 << `PIPE_REG_ADDR_W;

        data_t regs [NUM_REGS];

        // Write at the end of WB
        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (i_wb.valid && (i_wb.rd != '0)) begin
                        regs[i_wb.rd] <= i_wb.data;
                end
        end

        // Reads see a same cycle write so a reader three slots behind gets fresh data
        always_comb begin
                if (i_rs == '0)                            o_rs_data = '0;
                else if (i_wb.valid && (i_wb.rd == i_rs))  o_rs_data = i_wb.data;
                else                                       o_rs_data = regs[i_rs];

                if (i_rt == '0)                            o_rt_data = '0;
                else if (i_wb.valid && (i_wb.rd == i_rt))  o_rt_data = i_wb.data;
                else                                       o_rt_data = regs[i_rt];
        end

endmodule

// ==== source/forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit import pipe_pkg::*; (
        input  reg_addr_t i_ex_mem_rd,         // Destination held in EX/MEM
        input  reg_addr_t i_mem_wb_rd,         // Destination held in MEM/WB
        input  reg_addr_t i_rs,                // Source of operand A in EX
        input  reg_addr_t i_rt,                // Source of operand B in EX
        input  logic      i_ex_mem_write,      // EX instruction is a store
        input  logic      i_mem_write_reg,     // EX/MEM will write rd
        input  logic      i_wb_write_reg,      // MEM/WB will write rd
        output fwd_sel_e  o_forwarding_a,
        output fwd_sel_e  o_forwarding_b,
        output fwd_sel_e  o_forwarding_store
);

        // ##########################################################################
        // Producer lookup
        // ##########################################################################

        // Youngest producer wins so EX/MEM is checked before MEM/WB
        function automatic fwd_sel_e pick_source(
                input reg_addr_t src,
                input reg_addr_t mem_rd,
                input logic      mem_wr,
                input reg_addr_t wb_rd,
                input logic      wb_wr
        );
                fwd_sel_e sel;
                if (mem_wr && (mem_rd == src)) begin
                        sel = FWD_MEM;
                end else if (wb_wr && (wb_rd == src)) begin
                        sel = FWD_WB;
                end else begin
                        sel = FWD_NONE;                 // Register file value is current
                end
                return sel;
        endfunction

        // ##########################################################################
        // Selects
        // ##########################################################################
        always_comb begin
                o_forwarding_a     = pick_source(i_rs, i_ex_mem_rd, i_mem_write_reg,
                                                 i_mem_wb_rd, i_wb_write_reg);
                o_forwarding_store = pick_source(i_rt, i_ex_mem_rd, i_mem_write_reg,
                                                 i_mem_wb_rd, i_wb_write_reg);

                // Stores take the immediate as operand B
                if (i_ex_mem_write) begin
                        o_forwarding_b = FWD_NONE;
                end else begin
                        o_forwarding_b = o_forwarding_store;   // Same rt lookup
                end
        end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import pipe_pkg::*; (
        input  alu_op_e i_alu_op,
        input  data_t   i_a,           // Forwarded rs value
        input  data_t   i_b,           // Forwarded rt value or immediate
        output data_t   o_result
);

        // Sum and difference wrap at the word width
        always_comb begin
                case (i_alu_op)
                        ALU_ADD: begin
                                o_result = i_a + i_b;
                        end
                        ALU_SUB: begin
                                o_result = i_a - i_b;
                        end
                        ALU_AND: begin
                                o_result = i_a & i_b;
                        end
                        ALU_OR: begin
                                o_result = i_a | i_b;
                        end
                        default: begin
                                o_result = '0;
                        end
                endcase
        end

endmodule

// ==== source/data_memory.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module data_memory import pipe_pkg::*; (
        input  logic    i_clk,
        input  logic    i_rst,
        input  ex_mem_t i_ex_mem,        // Instruction in MEM
        output data_t   o_load_data      // Arrives together with the load in MEM/WB
);

        localparam int NUM_WORDS = 1 << `PIPE_DMEM_ADDR_W;

        data_t                        mem [NUM_WORDS];
        logic [`PIPE_DMEM_ADDR_W-1:0] addr;

        assign addr = i_ex_mem.alu_result[`PIPE_DMEM_ADDR_W-1:0];   // Word address

        // Store port
        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        for (int i = 0; i < NUM_WORDS; i++) begin
                                mem[i] <= '0;
                        end
                end else if (i_ex_mem.ctrl.mem_write) begin
                        mem[addr] <= i_ex_mem.store_data;
                end
        end

        // Registered load port
        always_ff @(posedge i_clk) begin
                if (i_ex_mem.ctrl.mem_read) begin
                        o_load_data <= mem[addr];
                end
        end

endmodule

// ==== source/exec_pipeline_top.sv ====
`timescale 1ns/1ps

module exec_pipeline_top import pipe_pkg::*; (
        input  logic   i_clk,
        input  logic   i_rst,
        input  instr_t i_instr,        // Decoded instruction entering ID
        output logic   o_stall,        // Hold i_instr this cycle
        output wb_t    o_wb            // Write-back result
);

        ctrl_t    dec_ctrl;
        data_t    rs_data, rt_data;      // ID register reads
        id_ex_t   id_ex;
        ex_mem_t  ex_mem;
        wb_t      mem_wb_q;              // MEM/WB with ALU result in data
        logic     mem_wb_load;           // MEM/WB holds a load
        wb_t      mem_wb;                // Resolved write-back view
        data_t    load_data;
        fwd_sel_e fwd_a, fwd_b, fwd_store;
        data_t    op_a, op_b, store_data, alu_b, alu_result;

        // Operand mux shared by A, B and store data
        function automatic data_t fwd_mux(input fwd_sel_e sel, input data_t id_val,
                                          input data_t mem_val, input data_t wb_val);
                case (sel)
                        FWD_MEM: return mem_val;
                        FWD_WB:  return wb_val;
                        default: return id_val;
                endcase
        endfunction

        // ##########################################################################
        // ID
        // ##########################################################################
        pipeline_control u_control (
                .i_instr          (i_instr),
                .i_id_ex_rd       (id_ex.rd),
                .i_id_ex_mem_read (id_ex.ctrl.mem_read),
                .o_ctrl           (dec_ctrl),
                .o_stall          (o_stall)
        );

        register_file u_regs (.i_clk(i_clk), .i_rst(i_rst), .i_rs(i_instr.rs), .i_rt(i_instr.rt),
                              .i_wb(mem_wb), .o_rs_data(rs_data), .o_rt_data(rt_data));

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        id_ex.ctrl <= '0;
                end else begin
                        id_ex.ctrl    <= o_stall ? '0 : dec_ctrl;  // Bubble on load-use
                        id_ex.rs      <= i_instr.rs;
                        id_ex.rt      <= i_instr.rt;
                        id_ex.rd      <= i_instr.rd;
                        id_ex.imm     <= i_instr.imm;
                        id_ex.rs_data <= rs_data;
                        id_ex.rt_data <= rt_data;
                end
        end

        // ##########################################################################
        // EX
        // ##########################################################################
        forwarding_unit u_fwd (
                .i_ex_mem_rd        (ex_mem.rd),
                .i_mem_wb_rd        (mem_wb_q.rd),
                .i_rs               (id_ex.rs),
                .i_rt               (id_ex.rt),
                .i_ex_mem_write     (id_ex.ctrl.mem_write),
                .i_mem_write_reg    (ex_mem.ctrl.write_reg),
                .i_wb_write_reg     (mem_wb_q.valid),
                .o_forwarding_a     (fwd_a),
                .o_forwarding_b     (fwd_b),
                .o_forwarding_store (fwd_store)
        );

        assign op_a       = fwd_mux(fwd_a, id_ex.rs_data, ex_mem.alu_result, mem_wb.data);
        assign op_b       = fwd_mux(fwd_b, id_ex.rt_data, ex_mem.alu_result, mem_wb.data);
        assign store_data = fwd_mux(fwd_store, id_ex.rt_data, ex_mem.alu_result, mem_wb.data);
        assign alu_b      = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

        alu u_alu (.i_alu_op(id_ex.ctrl.alu_op), .i_a(op_a), .i_b(alu_b), .o_result(alu_result));

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        ex_mem.ctrl <= '0;
                end else begin
                        ex_mem.ctrl       <= id_ex.ctrl;
                        ex_mem.rd         <= id_ex.rd;
                        ex_mem.alu_result <= alu_result;
                        ex_mem.store_data <= store_data;
                end
        end

        // ##########################################################################
        // MEM and WB
        // ##########################################################################
        data_memory u_dmem (.i_clk(i_clk), .i_rst(i_rst), .i_ex_mem(ex_mem), .o_load_data(load_data));

        always_ff @(posedge i_clk) begin
                if (i_rst) begin
                        mem_wb_q.valid <= 1'b0;
                        mem_wb_load    <= 1'b0;
                end else begin
                        mem_wb_q.valid <= ex_mem.ctrl.write_reg;
                        mem_wb_load    <= ex_mem.ctrl.mem_read;
                        mem_wb_q.rd    <= ex_mem.rd;
                        mem_wb_q.data  <= ex_mem.alu_result;
                end
        end

        // Load data comes out of the memory read register
        always_comb begin
                mem_wb       = mem_wb_q;
                mem_wb.data  = mem_wb_load ? load_data : mem_wb_q.data;
        end

        assign o_wb = mem_wb;

endmodule

// ==== testbench/tb_exec_pipeline.sv ====
`timescale 1ns/1ps
`include "pipe_config.svh"

module tb_exec_pipeline import pipe_pkg::*; ();

        localparam int NUM_DIRECTED = 34;
        localparam int NUM_RANDOM   = 300;
        localparam int TIMEOUT_CYCLES = 4 * (NUM_DIRECTED + NUM_RANDOM) + 20;
        localparam int NUM_REGS     = 1 << `PIPE_REG_ADDR_W;
        localparam int NUM_WORDS    = 1 << `PIPE_DMEM_ADDR_W;

        logic      i_clk = 1'b0;
        logic      i_rst;
        instr_t    i_instr;
        logic      o_stall;
        wb_t       o_wb;

        data_t     ref_regs [NUM_REGS];   // Reference register file
        data_t     ref_mem  [NUM_WORDS];  // Reference data memory
        wb_t       exp_q [$];             // Expected write-backs in issue order
        wb_t       head;                  // Entry matched against o_wb this cycle
        logic      head_ok = 1'b0;
        logic      rst_q = 1'b0;          // Reset was high at the previous edge
        logic      stall_q;
        logic [2:0] acc_wr;               // Accepted writers shifted once per edge
        logic      prev_load;             // Load accepted at the previous edge
        reg_addr_t prev_rd;
        logic      accept, stall_exp;

        exec_pipeline_top dut (.i_clk(i_clk), .i_rst(i_rst), .i_instr(i_instr),
                               .o_stall(o_stall), .o_wb(o_wb));

        always #50 i_clk = ~i_clk;        // 100 ns period

        // ##########################################################################
        // Helpers
        // ##########################################################################
        function automatic instr_t make_instr(opcode_e op, int rd, int rs, int rt, data_t imm);
                instr_t ins;
                ins.valid  = 1'b1;
                ins.opcode = op;
                ins.rd     = reg_addr_t'(rd);
                ins.rs     = reg_addr_t'(rs);
                ins.rt     = reg_addr_t'(rt);
                ins.imm    = imm;
                return ins;
        endfunction

        // Register writers with a nonzero destination
        function automatic logic writes_rd(instr_t ins);
                return ins.valid && (ins.rd != '0) &&
                       (ins.opcode inside {ADD, SUB, AND, OR, ADDI, LW});
        endfunction

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("CHECKS FAILED");
                $fatal(1, "Run stopped at the first failure");
        endtask

        // In-order execution of one accepted instruction
        task automatic run_model(input instr_t ins);
                data_t a, b, res, sum;
                logic [`PIPE_DMEM_ADDR_W-1:0] addr;
                a    = ref_regs[ins.rs];
                b    = ref_regs[ins.rt];
                sum  = a + ins.imm;                 // Also the load and store address
                addr = sum[`PIPE_DMEM_ADDR_W-1:0];
                res  = '0;
                case (ins.opcode)
                        ADD:  res = a + b;
                        SUB:  res = a - b;
                        AND:  res = a & b;
                        OR:   res = a | b;
                        ADDI: res = sum;
                        LW:   res = ref_mem[addr];
                        SW:   if (ins.valid) ref_mem[addr] = b;
                        default: ;
                endcase
                if (writes_rd(ins)) begin
                        ref_regs[ins.rd] = res;
                        exp_q.push_back('{valid: 1'b1, rd: ins.rd, data: res});
                end
        endtask

        // Drive after the edge and hold through stalls until the DUT takes it
        task automatic issue_instr(input instr_t ins);
                @(posedge i_clk);
                #1 i_instr = ins;
                @(negedge i_clk);
                while (o_stall) begin
                        @(negedge i_clk);           // Held one more cycle
                end
                run_model(ins);
        endtask

        // ##########################################################################
        // Expected timing and stall tracking
        // ##########################################################################
        assign accept    = i_instr.valid && !o_stall;
        assign stall_exp = i_instr.valid && prev_load &&
                           ((i_instr.rs == prev_rd) || (i_instr.rt == prev_rd));

        always @(posedge i_clk) begin
                rst_q   <= i_rst;
                stall_q <= o_stall;
                if (i_rst) begin
                        acc_wr    <= '0;
                        prev_load <= 1'b0;
                        prev_rd   <= '0;
                end else begin
                        acc_wr    <= {acc_wr[1:0], accept && writes_rd(i_instr)};
                        prev_load <= accept && (i_instr.opcode == LW);
                        prev_rd   <= i_instr.rd;
                end
        end

        // Match each write-back to the oldest expected entry
        always @(negedge i_clk) begin
                head_ok = 1'b0;
                if (o_wb.valid && (exp_q.size() > 0)) begin
                        head    = exp_q.pop_front();
                        head_ok = 1'b1;
                end
        end

        // ##########################################################################
        // Assertions
        // ##########################################################################
        assert property (@(posedge i_clk) (i_rst && rst_q) |-> (!o_wb.valid && !o_stall))
                else report_failure("Write-back or stall active during reset");
        assert property (@(posedge i_clk) !i_rst |-> (o_wb.valid == acc_wr[2]))
                else report_failure($sformatf("Error: o_wb.valid = %h, expected %h",
                                    $sampled(o_wb.valid), $sampled(acc_wr[2])));
        assert property (@(posedge i_clk) (!i_rst && o_wb.valid) |-> head_ok)
                else report_failure("Write-back seen with no expected result pending");
        assert property (@(posedge i_clk) (o_wb.valid && head_ok) |-> (o_wb.rd == head.rd))
                else report_failure($sformatf("Error: o_wb.rd = %h, expected %h",
                                    $sampled(o_wb.rd), $sampled(head.rd)));
        assert property (@(posedge i_clk) (o_wb.valid && head_ok) |-> (o_wb.data == head.data))
                else report_failure($sformatf("Error: o_wb.data = %h, expected %h",
                                    $sampled(o_wb.data), $sampled(head.data)));
        assert property (@(posedge i_clk) !i_rst |-> (o_stall == stall_exp))
                else report_failure($sformatf("Error: o_stall = %h, expected %h",
                                    $sampled(o_stall), $sampled(stall_exp)));
        assert property (@(posedge i_clk) !i_rst |-> !(o_stall && stall_q))
                else report_failure("Stall held for two consecutive cycles");

        // Watchdog
        initial begin
                repeat (TIMEOUT_CYCLES) @(posedge i_clk);
                report_failure($sformatf("Timeout after %0d cycles", TIMEOUT_CYCLES));
        end

        // ##########################################################################
        // Program
        // ##########################################################################
        initial begin
                instr_t ins;
                void'($urandom(27857));
                i_rst    = 1'b1;
                i_instr  = '0;
                for (int i = 0; i < NUM_REGS; i++) ref_regs[i] = '0;
                for (int i = 0; i < NUM_WORDS; i++) ref_mem[i] = '0;
                repeat (2) @(posedge i_clk);
                #1 i_rst = 1'b0;

                issue_instr(make_instr(LW,   1, 0, 0, 16'h0000));  // Loads before any store
                issue_instr(make_instr(LW,   2, 0, 0, 16'h0009));
                issue_instr(make_instr(ADDI, 1, 0, 0, 16'h7fff));
                issue_instr(make_instr(ADDI, 2, 0, 0, 16'hfff0));
                issue_instr(make_instr(ADD,  3, 1, 2, 16'h0000));  // A from WB and B from MEM
                issue_instr(make_instr(SUB,  4, 3, 1, 16'h0000));
                issue_instr(make_instr(AND,  5, 4, 3, 16'h0000));
                issue_instr(make_instr(OR,   6, 5, 4, 16'h0000));
                issue_instr(make_instr(ADDI, 7, 7, 0, 16'hffff));
                issue_instr(make_instr(ADDI, 7, 7, 0, 16'h0002));  // Wraps to 1
                issue_instr(make_instr(SUB,  6, 0, 7, 16'h0000));  // Wraps below zero
                issue_instr(make_instr(ADDI, 1, 0, 0, 16'h1234));
                issue_instr(make_instr(NOP,  0, 0, 0, 16'h0000));
                issue_instr(make_instr(NOP,  0, 0, 0, 16'h0000));
                issue_instr(make_instr(ADD,  2, 1, 0, 16'h0000));  // Register file write-through
                issue_instr(make_instr(ADDI, 0, 0, 0, 16'h0005));  // r0 never written
                issue_instr(make_instr(ADD,  1, 0, 0, 16'h0000));
                issue_instr(make_instr(ADDI, 3, 0, 0, 16'h0abc));
                issue_instr(make_instr(SW,   0, 0, 3, 16'h0004));  // Store data from MEM
                issue_instr(make_instr(ADDI, 5, 0, 0, 16'h0003));
                issue_instr(make_instr(ADDI, 4, 0, 0, 16'h0def));
                issue_instr(make_instr(NOP,  0, 0, 0, 16'h0000));
                issue_instr(make_instr(SW,   0, 5, 4, 16'h0002));  // Store data from WB
                issue_instr(make_instr(LW,   6, 0, 0, 16'h0004));
                issue_instr(make_instr(LW,   7, 5, 0, 16'h0002));
                issue_instr(make_instr(ADD,  2, 6, 7, 16'h0000));  // Load-use stall
                issue_instr(make_instr(LW,   3, 0, 0, 16'h0005));
                issue_instr(make_instr(SW,   0, 0, 3, 16'h0006));  // Stall then load data from WB
                issue_instr(make_instr(LW,   4, 0, 0, 16'h0006));
                issue_instr(make_instr(NOP,  0, 0, 0, 16'h0000));
                issue_instr(make_instr(ADD,  5, 4, 4, 16'h0000));
                issue_instr(make_instr(ADDI, 5, 0, 0, 16'h0008));
                issue_instr(make_instr(SW,   0, 5, 2, 16'h0001));  // Base forwarded from MEM
                issue_instr(make_instr(LW,   1, 0, 0, 16'h0009));

                // Small register and address range so dependences are frequent
                for (int n = 0; n < NUM_RANDOM; n++) begin
                        ins = make_instr(opcode_e'($urandom_range(0, 7)), $urandom_range(0, 7),
                                         $urandom_range(0, 7), $urandom_range(0, 7),
                                         data_t'($urandom));
                        ins.valid = ($urandom_range(0, 7) != 0);
                        issue_instr(ins);
                end

                @(posedge i_clk);
                #1 i_instr = '0;
                while (exp_q.size() != 0) @(posedge i_clk);
                repeat (3) @(posedge i_clk);                        // Last compare and idle tail
                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

// ==== tb.f ====
+incdir+source
source/pipe_pkg.sv
source/pipeline_control.sv
source/register_file.sv
source/forwarding_unit.sv
source/alu.sv
source/data_memory.sv
source/exec_pipeline_top.sv
testbench/tb_exec_pipeline.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_exec_pipeline
FILELIST = tb.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation exits with a nonzero status on any failing check
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
